// File: rtl/mipsPkg.sv
// shared constants for the single-cycle MIPS32 subset core
// only add, sub, and, or, slt, lw, sw, beq, j, jal and jr are decoded
// data memory is word addressed, 128 words, address from ALU result bits 8 to 2
`default_nettype none

package mipsPkg;

  // ========================================
  // widths and indices
  // ========================================
  localparam int dataWidth    = 32;
  localparam int regAddrWidth = 5;
  localparam int numRegs      = 32;
  localparam int memAddrWidth = 7;
  localparam int opWidth      = 6;

  // jal writes its return address here
  localparam logic [regAddrWidth-1:0] linkReg = 5'd31;

  // ========================================
  // opcode field, bits 31 to 26
  // ========================================
  localparam logic [opWidth-1:0] opRType = 6'h00;
  localparam logic [opWidth-1:0] opJ     = 6'h02;
  localparam logic [opWidth-1:0] opJal   = 6'h03;
  localparam logic [opWidth-1:0] opBeq   = 6'h04;
  localparam logic [opWidth-1:0] opLw    = 6'h23;
  localparam logic [opWidth-1:0] opSw    = 6'h2b;

  // ========================================
  // funct field for R-type, bits 5 to 0
  // ========================================
  localparam logic [opWidth-1:0] fnJr  = 6'h08;
  localparam logic [opWidth-1:0] fnAdd = 6'h20;
  localparam logic [opWidth-1:0] fnSub = 6'h22;
  localparam logic [opWidth-1:0] fnAnd = 6'h24;
  localparam logic [opWidth-1:0] fnOr  = 6'h25;
  localparam logic [opWidth-1:0] fnSlt = 6'h2a;

  // alu operations, aluNone gives a zero result
  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluSlt,
    aluNone
  } aluOp_e;

endpackage

`default_nettype wire

// File: rtl/mipsControl.sv
// main decoder for the single-cycle core, purely combinational
// unknown opcodes and functs decode to a no-op: no register or memory write
// register and memory writes are held off while rst is low
`timescale 1ns/1ps
`default_nettype none

module mipsControl (
  input  logic                        rst,
  input  logic [mipsPkg::opWidth-1:0] opcode,
  input  logic [mipsPkg::opWidth-1:0] funct,
  output logic                        regDst,
  output logic                        aluSrc,
  output logic                        memToReg,
  output logic                        regWrite,
  output logic                        memWrite,
  output logic                        branch,
  output logic                        jump,
  output logic                        link,
  output logic                        jumpReg,
  output mipsPkg::aluOp_e             aluOp
);
  import mipsPkg::*;

  // decoded enables before the reset hold
  logic regWriteDec;
  logic memWriteDec;

  always_comb begin
    // defaults give a no-op
    regDst      = 1'b0;
    aluSrc      = 1'b0;
    memToReg    = 1'b0;
    regWriteDec = 1'b0;
    memWriteDec = 1'b0;
    branch      = 1'b0;
    jump        = 1'b0;
    link        = 1'b0;
    jumpReg     = 1'b0;
    aluOp       = aluNone;
    case (opcode)
      opRType: begin
        // write goes to rd
        regDst = 1'b1;
        case (funct)
          fnAdd: begin
            aluOp       = aluAdd;
            regWriteDec = 1'b1;
          end
          fnSub: begin
            aluOp       = aluSub;
            regWriteDec = 1'b1;
          end
          fnAnd: begin
            aluOp       = aluAnd;
            regWriteDec = 1'b1;
          end
          fnOr: begin
            aluOp       = aluOr;
            regWriteDec = 1'b1;
          end
          fnSlt: begin
            aluOp       = aluSlt;
            regWriteDec = 1'b1;
          end
          // jr only redirects the pc
          fnJr:    jumpReg = 1'b1;
          default: regDst  = 1'b1;
        endcase
      end
      opLw: begin
        // base plus offset, result from memory into rt
        aluSrc      = 1'b1;
        memToReg    = 1'b1;
        regWriteDec = 1'b1;
        aluOp       = aluAdd;
      end
      opSw: begin
        aluSrc      = 1'b1;
        memWriteDec = 1'b1;
        aluOp       = aluAdd;
      end
      opBeq: begin
        // equal when rs - rt is zero
        branch = 1'b1;
        aluOp  = aluSub;
      end
      opJ:     jump = 1'b1;
      opJal: begin
        jump        = 1'b1;
        link        = 1'b1;
        regWriteDec = 1'b1;
      end
      default: aluOp = aluNone;
    endcase
  end

  // no state change while in reset
  assign regWrite = rst & regWriteDec;
  assign memWrite = rst & memWriteDec;

endmodule

`default_nettype wire

// File: rtl/mipsAlu.sv
// combinational ALU for the core
// slt is a signed compare, no overflow detection anywhere
`timescale 1ns/1ps
`default_nettype none

module mipsAlu (
  input  logic [mipsPkg::dataWidth-1:0] a,
  input  logic [mipsPkg::dataWidth-1:0] b,
  input  mipsPkg::aluOp_e               aluOp,
  output logic [mipsPkg::dataWidth-1:0] result,
  output logic                          zero
);
  import mipsPkg::*;

  // signed view of the operands for slt
  logic lessThan;

  assign lessThan = $signed(a) < $signed(b);

  always_comb begin
    case (aluOp)
      aluAdd:  result = a + b;
      aluSub:  result = a - b;
      aluAnd:  result = a & b;
      aluOr:   result = a | b;
      // one in bit 0, the rest cleared
      aluSlt:  result = {{(dataWidth-1){1'b0}}, lessThan};
      aluNone: result = '0;
      default: result = '0;
    endcase
  end

  // flag is valid for every operation, beq reads it after a subtract
  assign zero = (result == '0);

endmodule

`default_nettype wire

// File: rtl/mipsRegFile.sv
// 32 x 32 register file, two combinational reads and one clocked write
// register 0 ignores writes and always reads zero
// all entries are cleared by the asynchronous reset
`timescale 1ns/1ps
`default_nettype none

module mipsRegFile (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [mipsPkg::regAddrWidth-1:0] readAddrA,
  input  logic [mipsPkg::regAddrWidth-1:0] readAddrB,
  input  logic                             writeEn,
  input  logic [mipsPkg::regAddrWidth-1:0] writeAddr,
  input  logic [mipsPkg::dataWidth-1:0]    writeData,
  output logic [mipsPkg::dataWidth-1:0]    readDataA,
  output logic [mipsPkg::dataWidth-1:0]    readDataB
);
  import mipsPkg::*;

  logic [dataWidth-1:0] regs [numRegs];

  // ========================================
  // write port
  // ========================================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn && (writeAddr != '0)) begin
      // writes naming r0 are dropped here
      regs[writeAddr] <= writeData;
    end
  end

  // read ports, r0 forced to zero
  assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
  assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

`default_nettype wire

// File: rtl/mipsPc.sv
// program counter and next-address logic
// no delay slot, a taken branch or jump redirects the very next fetch
// priority is jr, then j/jal, then taken beq, then pc + 4
`timescale 1ns/1ps
`default_nettype none

module mipsPc (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          branch,
  input  logic                          zero,
  input  logic                          jump,
  input  logic                          jumpReg,
  input  logic [mipsPkg::dataWidth-1:0] branchOffset,
  input  logic [25:0]                   jumpIndex,
  input  logic [mipsPkg::dataWidth-1:0] regTarget,
  output logic [mipsPkg::dataWidth-1:0] pc,
  output logic [mipsPkg::dataWidth-1:0] pcPlus8
);
  import mipsPkg::*;

  logic [dataWidth-1:0] pcReg;
  logic [dataWidth-1:0] pcPlus4;
  logic [dataWidth-1:0] pcNext;
  logic [dataWidth-1:0] branchTarget;
  logic                 branchTaken;

  assign pcPlus4      = pcReg + dataWidth'(4);
  // return address for jal
  assign pcPlus8      = pcReg + dataWidth'(8);
  assign branchTaken  = branch & zero;
  // word offset relative to the following instruction
  assign branchTarget = pcPlus4 + (branchOffset << 2);

  always_comb begin
    if (jumpReg) begin
      pcNext = regTarget;
    end else if (jump) begin
      // region bits kept from pc + 4
      pcNext = {pcPlus4[dataWidth-1 -: 4], jumpIndex, 2'b00};
    end else if (branchTaken) begin
      pcNext = branchTarget;
    end else begin
      pcNext = pcPlus4;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pcReg <= '0;
    end else begin
      pcReg <= pcNext;
    end
  end

  assign pc = pcReg;

endmodule

`default_nettype wire

// File: rtl/singleCycleMips.sv
// single-cycle MIPS32 subset core
// instruction and data memories are external and must answer in the same cycle
// memWen is active low and the store happens on the rising edge
// memAddr is a word address taken from ALU result bits 8 to 2
// rfWrite* mirror the write-back of the current instruction for observation
`timescale 1ns/1ps
`default_nettype none

module singleCycleMips (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [mipsPkg::dataWidth-1:0]    ir,
  input  logic [mipsPkg::dataWidth-1:0]    readDataMem,
  output logic [mipsPkg::dataWidth-1:0]    irAddr,
  output logic [mipsPkg::memAddrWidth-1:0] memAddr,
  output logic [mipsPkg::dataWidth-1:0]    writeDataMem,
  output logic                             memWen,
  output logic                             rfWriteEn,
  output logic [mipsPkg::regAddrWidth-1:0] rfWriteAddr,
  output logic [mipsPkg::dataWidth-1:0]    rfWriteData
);
  import mipsPkg::*;

  // instruction fields
  logic [opWidth-1:0]      opcode;
  logic [opWidth-1:0]      funct;
  logic [regAddrWidth-1:0] rs;
  logic [regAddrWidth-1:0] rt;
  logic [regAddrWidth-1:0] rd;
  logic [15:0]             imm;
  logic [25:0]             jumpIndex;
  logic [dataWidth-1:0]    immExt;

  // decoder outputs
  logic   regDst;
  logic   aluSrc;
  logic   memToReg;
  logic   regWrite;
  logic   memWrite;
  logic   branch;
  logic   jump;
  logic   link;
  logic   jumpReg;
  aluOp_e aluOp;

  // datapath
  logic [dataWidth-1:0] rsData;
  logic [dataWidth-1:0] rtData;
  logic [dataWidth-1:0] aluB;
  logic [dataWidth-1:0] aluResult;
  logic                 aluZero;
  logic [dataWidth-1:0] pc;
  logic [dataWidth-1:0] pcPlus8;

  // ========================================
  // field slicing
  // ========================================
  assign opcode    = ir[31:26];
  assign rs        = ir[25:21];
  assign rt        = ir[20:16];
  assign rd        = ir[15:11];
  assign funct     = ir[5:0];
  assign imm       = ir[15:0];
  assign jumpIndex = ir[25:0];
  assign immExt    = {{(dataWidth-16){imm[15]}}, imm};

  mipsControl i_control (
    .rst     (rst),
    .opcode  (opcode),
    .funct   (funct),
    .regDst  (regDst),
    .aluSrc  (aluSrc),
    .memToReg(memToReg),
    .regWrite(regWrite),
    .memWrite(memWrite),
    .branch  (branch),
    .jump    (jump),
    .link    (link),
    .jumpReg (jumpReg),
    .aluOp   (aluOp)
  );

  mipsRegFile i_regFile (
    .clk      (clk),
    .rst      (rst),
    .readAddrA(rs),
    .readAddrB(rt),
    .writeEn  (regWrite),
    .writeAddr(rfWriteAddr),
    .writeData(rfWriteData),
    .readDataA(rsData),
    .readDataB(rtData)
  );

  // immediate for lw and sw and rt for the rest
  assign aluB = aluSrc ? immExt : rtData;

  mipsAlu i_alu (
    .a     (rsData),
    .b     (aluB),
    .aluOp (aluOp),
    .result(aluResult),
    .zero  (aluZero)
  );

  mipsPc i_pc (
    .clk         (clk),
    .rst         (rst),
    .branch      (branch),
    .zero        (aluZero),
    .jump        (jump),
    .jumpReg     (jumpReg),
    .branchOffset(immExt),
    .jumpIndex   (jumpIndex),
    .regTarget   (rsData),
    .pc          (pc),
    .pcPlus8     (pcPlus8)
  );

  // ========================================
  // write-back selection
  // ========================================
  always_comb begin
    if (link) begin
      rfWriteAddr = linkReg;
    end else if (regDst) begin
      rfWriteAddr = rd;
    end else begin
      rfWriteAddr = rt;
    end
  end

  always_comb begin
    if (link) begin
      rfWriteData = pcPlus8;
    end else if (memToReg) begin
      rfWriteData = readDataMem;
    end else begin
      rfWriteData = aluResult;
    end
  end

  assign rfWriteEn = regWrite;

  // memory ports
  assign irAddr       = pc;
  assign memAddr      = aluResult[memAddrWidth+1:2];
  assign writeDataMem = rtData;
  assign memWen       = ~memWrite;

endmodule

`default_nettype wire

// File: tests/singleCycleMips_sva.sv
// concurrent checks on the core ports, attached with bind
// r0 read-back is seen through sw of r0 on writeDataMem
// sampled on the rising edge of clk
`timescale 1ns/1ps
`default_nettype none

module singleCycleMips_sva (
  input logic                          clk,
  input logic                          rst,
  input logic [mipsPkg::dataWidth-1:0] ir,
  input logic [mipsPkg::dataWidth-1:0] irAddr,
  input logic [mipsPkg::dataWidth-1:0] writeDataMem,
  input logic                          memWen,
  input logic                          rfWriteEn
);
  import mipsPkg::*;

  // no state change may be requested while in reset
  quietInReset: assert property (@(posedge clk) !rst |-> (!rfWriteEn && memWen))
    else $error("register or memory write requested during reset");

  // fetch address on word boundaries
  alignedFetch: assert property (@(posedge clk) disable iff (!rst) irAddr[1:0] == 2'b00)
    else $error("instruction address not word aligned");

  // sw of r0 must store zero, whatever was written to r0 before
  zeroReadBack: assert property (@(posedge clk) disable iff (!rst)
    (ir[31:26] == opSw && ir[20:16] == '0) |-> writeDataMem == '0)
    else $error("register 0 read back as nonzero");

endmodule

bind singleCycleMips singleCycleMips_sva i_sva (.*);

`default_nettype wire

// File: tests/mipsRefModel.svh
// instruction-set reference model for the testbench, included inside its module
// mipsRefStep executes one instruction and updates the model state
// writes naming r0 are reported but leave refRegs[0] at zero
// no delay slot, jal links pc + 8
`ifndef MIPS_REF_MODEL_SVH
`define MIPS_REF_MODEL_SVH

import mipsPkg::*;

// model state
logic [dataWidth-1:0] refRegs [numRegs];
logic [dataWidth-1:0] refMem [2**memAddrWidth];
logic [dataWidth-1:0] refPc;

// expected effects of one instruction
typedef struct packed {
  logic [dataWidth-1:0]    nextPc;
  logic                    rfWe;
  logic [regAddrWidth-1:0] rfAddr;
  logic [dataWidth-1:0]    rfData;
  logic                    memWe;
  logic [memAddrWidth-1:0] memAddr;
  logic [dataWidth-1:0]    memData;
} refStep_t;

// registers and pc back to their reset values
function automatic void mipsRefReset();
  for (int i = 0; i < numRegs; i++) begin
    refRegs[i] = '0;
  end
  refPc = '0;
endfunction

function automatic refStep_t mipsRefStep(input logic [dataWidth-1:0] inst);
  refStep_t             step;
  logic [dataWidth-1:0] a;
  logic [dataWidth-1:0] b;
  logic [dataWidth-1:0] immExt;
  logic [dataWidth-1:0] pc4;
  logic [dataWidth-1:0] ea;
  immExt      = {{(dataWidth-16){inst[15]}}, inst[15:0]};
  a           = refRegs[inst[25:21]];
  b           = refRegs[inst[20:16]];
  pc4         = refPc + dataWidth'(4);
  ea          = a + immExt;
  step        = '0;
  step.nextPc = pc4;
  step.rfAddr = inst[15:11];
  case (inst[31:26])
    opRType: begin
      step.rfWe = inst[5:0] inside {fnAdd, fnSub, fnAnd, fnOr, fnSlt};
      case (inst[5:0])
        fnAdd:   step.rfData = a + b;
        fnSub:   step.rfData = a - b;
        fnAnd:   step.rfData = a & b;
        fnOr:    step.rfData = a | b;
        fnSlt:   step.rfData = {{(dataWidth-1){1'b0}}, $signed(a) < $signed(b)};
        fnJr:    step.nextPc = a;
        default: step.rfWe = 1'b0;
      endcase
    end
    opLw: begin
      step.rfWe   = 1'b1;
      step.rfAddr = inst[20:16];
      step.rfData = refMem[ea[memAddrWidth+1:2]];
    end
    opSw: begin
      step.memWe   = 1'b1;
      step.memAddr = ea[memAddrWidth+1:2];
      step.memData = b;
    end
    opBeq: begin
      if (a == b) begin
        step.nextPc = pc4 + (immExt << 2);
      end
    end
    opJ:   step.nextPc = {pc4[31:28], inst[25:0], 2'b00};
    opJal: begin
      step.nextPc = {pc4[31:28], inst[25:0], 2'b00};
      step.rfWe   = 1'b1;
      step.rfAddr = linkReg;
      step.rfData = refPc + dataWidth'(8);
    end
    default: step.rfWe = 1'b0;
  endcase
  // commit to the model
  if (step.rfWe && (step.rfAddr != '0)) begin
    refRegs[step.rfAddr] = step.rfData;
  end
  if (step.memWe) begin
    refMem[step.memAddr] = step.memData;
  end
  refPc = step.nextPc;
  return step;
endfunction

`endif

// File: tests/tbSingleCycleMips.sv
// testbench for the single-cycle core
// instruction and data memories are modeled here and answer combinationally
// each section is run from its own reset and ends in a self-jump halt
// data memory is filled once from the LCG and carries over between sections
`timescale 1ns/1ps
`default_nettype none

module tbSingleCycleMips;
  `include "mipsRefModel.svh"

  localparam int haltTimeout = 2000;
  localparam int numSections = 6;

  logic                    clk;
  logic                    rst;
  logic [dataWidth-1:0]    ir;
  logic [dataWidth-1:0]    readDataMem;
  logic [dataWidth-1:0]    irAddr;
  logic [memAddrWidth-1:0] memAddr;
  logic [dataWidth-1:0]    writeDataMem;
  logic                    memWen;
  logic                    rfWriteEn;
  logic [regAddrWidth-1:0] rfWriteAddr;
  logic [dataWidth-1:0]    rfWriteData;

  // memory arrays and run state
  logic [dataWidth-1:0] instMem [256];
  logic [dataWidth-1:0] dataMem [2**memAddrWidth];
  logic [dataWidth-1:0] lcgState;
  logic [dataWidth-1:0] haltAddr;
  int                   progPtr;
  int                   checkErrors;
  int                   failedTests;
  int                   testsRun;
  bit                   checking;
  bit                   timedOut;
  refStep_t             expStep;

  singleCycleMips i_dut (
    .clk         (clk),
    .rst         (rst),
    .ir          (ir),
    .readDataMem (readDataMem),
    .irAddr      (irAddr),
    .memAddr     (memAddr),
    .writeDataMem(writeDataMem),
    .memWen      (memWen),
    .rfWriteEn   (rfWriteEn),
    .rfWriteAddr (rfWriteAddr),
    .rfWriteData (rfWriteData)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ========================================
  // memory models
  // ========================================
  assign ir          = instMem[irAddr[9:2]];
  assign readDataMem = dataMem[memAddr];

  always @(posedge clk) begin
    if (!memWen) begin
      dataMem[memAddr] <= writeDataMem;
    end
  end

  // ========================================
  // comparison of one instruction per cycle
  // ========================================
  always @(negedge clk) begin
    if (!rst) begin
      mipsRefReset();
      if (irAddr !== '0) flagMismatch("irAddr during reset", irAddr, '0);
      if (memWen !== 1'b1) flagMismatch("memWen during reset", 32'(memWen), 32'(1));
      if (rfWriteEn !== 1'b0) flagMismatch("rfWriteEn during reset", 32'(rfWriteEn), '0);
    end else if (checking) begin
      if (irAddr !== refPc) flagMismatch("irAddr", irAddr, refPc);
      expStep = mipsRefStep(instMem[refPc[9:2]]);
      if (rfWriteEn !== expStep.rfWe) begin
        flagMismatch("rfWriteEn", 32'(rfWriteEn), 32'(expStep.rfWe));
      end
      if (expStep.rfWe) begin
        if (rfWriteAddr !== expStep.rfAddr) begin
          flagMismatch("rfWriteAddr", 32'(rfWriteAddr), 32'(expStep.rfAddr));
        end
        if (rfWriteData !== expStep.rfData) begin
          flagMismatch("rfWriteData", rfWriteData, expStep.rfData);
        end
      end
      // memWen low means a store
      if (memWen !== !expStep.memWe) flagMismatch("memWen", 32'(memWen), 32'(!expStep.memWe));
      if (expStep.memWe) begin
        if (memAddr !== expStep.memAddr) begin
          flagMismatch("memAddr", 32'(memAddr), 32'(expStep.memAddr));
        end
        if (writeDataMem !== expStep.memData) begin
          flagMismatch("writeDataMem", writeDataMem, expStep.memData);
        end
      end
    end
  end

  task automatic flagMismatch(input string what, input logic [31:0] got, input logic [31:0] want);
    checkErrors++;
    $display("mismatch at %0d ns: %s is %h, expected %h", $time, what, got, want);
  endtask

  // ========================================
  // stimulus helpers
  // ========================================
  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [31:0] rInst(input logic [5:0] fn, input int rd, input int rs,
                                        input int rt);
    return {opRType, 5'(rs), 5'(rt), 5'(rd), 5'b0, fn};
  endfunction

  function automatic logic [31:0] iInst(input logic [5:0] op, input int rs, input int rt,
                                        input int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
  endfunction

  function automatic logic [31:0] jInst(input logic [5:0] op, input int index);
    return {op, 26'(index)};
  endfunction

  task automatic emit(input logic [31:0] word);
    instMem[8'(progPtr)] = word;
    progPtr++;
  endtask

  // jump to a self-jump right behind it
  task automatic endSection();
    int h;
    h        = progPtr + 1;
    haltAddr = 32'(h * 4);
    emit(jInst(opJ, h));
    emit(jInst(opJ, h));
  endtask

  // random words plus a few fixed ones for sign and loop count
  task automatic fillData();
    for (int i = 0; i < 2**memAddrWidth; i++) begin
      lcgState       = lcgNext(lcgState);
      dataMem[7'(i)] = lcgState;
    end
    dataMem[0]   = dataMem[0] | 32'h8000_0000;
    dataMem[1]   = dataMem[1] & 32'h7fff_ffff;
    dataMem[120] = 32'd1;
    dataMem[121] = 32'd5;
    for (int i = 0; i < 2**memAddrWidth; i++) begin
      refMem[7'(i)] = dataMem[7'(i)];
    end
  endtask

  // ========================================
  // programs
  // ========================================
  task automatic buildProgram(input int id);
    case (id)
      0: begin
        for (int k = 1; k <= 4; k++) emit(iInst(opLw, 0, k, 4 * (k - 1)));
        emit(rInst(fnAdd, 5, 1, 2));
        emit(rInst(fnSub, 6, 1, 2));
        emit(rInst(fnAnd, 7, 3, 4));
        emit(rInst(fnOr, 8, 3, 4));
        // r1 negative and r2 positive
        emit(rInst(fnSlt, 9, 1, 2));
        emit(rInst(fnSlt, 10, 2, 1));
        emit(rInst(fnSlt, 11, 3, 4));
        emit(rInst(fnSub, 12, 0, 2));
        emit(rInst(fnSlt, 13, 12, 1));
        emit(rInst(fnAdd, 14, 5, 6));
        emit(iInst(opSw, 0, 14, 40));
        endSection();
      end
      1: begin
        // registers held alu results before this reset
        // every register to words 64..95
        for (int k = 0; k < numRegs; k++) emit(iInst(opSw, 0, k, 256 + 4 * k));
        endSection();
      end
      2: begin
        // count r1 down from 5 while r3 counts up
        emit(iInst(opLw, 0, 1, 484));
        emit(iInst(opLw, 0, 2, 480));
        emit(rInst(fnAdd, 3, 0, 0));
        emit(rInst(fnAdd, 3, 3, 2));
        emit(rInst(fnSub, 1, 1, 2));
        emit(iInst(opBeq, 1, 0, 1));
        emit(iInst(opBeq, 0, 0, -4));
        // never taken since r1 is 0 and r2 is 1
        emit(iInst(opBeq, 1, 2, 5));
        emit(iInst(opSw, 0, 3, 400));
        endSection();
      end
      3: begin
        emit(iInst(opLw, 0, 1, 16));
        emit(iInst(opLw, 0, 2, 20));
        emit(iInst(opSw, 0, 1, 100));
        emit(iInst(opSw, 0, 2, 104));
        emit(iInst(opLw, 0, 5, 24));
        emit(iInst(opSw, 5, 1, -8));
        emit(iInst(opSw, 5, 2, 36));
        emit(iInst(opLw, 5, 6, -8));
        emit(iInst(opLw, 5, 7, 36));
        emit(iInst(opLw, 0, 8, 100));
        emit(iInst(opLw, 0, 9, 104));
        // 512 folds onto word 0
        emit(iInst(opSw, 0, 1, 512));
        emit(iInst(opLw, 0, 10, 0));
        endSection();
      end
      4: begin
        emit(iInst(opLw, 0, 1, 0));
        emit(jInst(opJ, 3));
        emit(rInst(fnAdd, 2, 1, 1));
        emit(jInst(opJal, 8));
        // skipped since the return lands on jal + 8
        emit(rInst(fnAdd, 5, 1, 1));
        emit(iInst(opSw, 0, 4, 200));
        endSection();
        // subroutine at word 8
        emit(rInst(fnAdd, 4, 1, 1));
        emit(iInst(opSw, 0, 31, 204));
        emit(rInst(fnJr, 0, 31, 0));
      end
      default: begin
        emit(iInst(opLw, 0, 1, 4));
        emit(iInst(opLw, 0, 0, 8));
        emit(rInst(fnAdd, 0, 1, 1));
        emit(rInst(fnOr, 0, 1, 1));
        emit(iInst(opSw, 0, 0, 300));
        emit(rInst(fnAdd, 2, 0, 1));
        emit(iInst(opSw, 0, 2, 304));
        emit(rInst(fnSub, 3, 1, 0));
        emit(rInst(fnSlt, 4, 0, 0));
        endSection();
      end
    endcase
  endtask

  function automatic string sectionName(input int id);
    case (id)
      0:       return "alu";
      1:       return "reset";
      2:       return "branch";
      3:       return "memory";
      4:       return "jump";
      default: return "regzero";
    endcase
  endfunction

  // ========================================
  // section run
  // ========================================
  task automatic waitForHalt(output bit reached);
    int cycles;
    reached = 1'b0;
    cycles  = 0;
    while (!reached && cycles < haltTimeout) begin
      @(negedge clk);
      cycles++;
      if (irAddr === haltAddr) reached = 1'b1;
    end
  endtask

  task automatic runSection(input int id);
    int  errStart;
    bit  reached;
    @(posedge clk);
    rst      <= 1'b0;
    checking = 1'b0;
    for (int i = 0; i < 256; i++) instMem[8'(i)] = '0;
    progPtr = 0;
    buildProgram(id);
    repeat (8) @(posedge clk);
    rst      <= 1'b1;
    checking = 1'b1;
    errStart = checkErrors;
    testsRun++;
    waitForHalt(reached);
    @(posedge clk);
    if (!reached) begin
      timedOut = 1'b1;
      failedTests++;
      $display("test %s: timed out, halt address %h not reached in %0d cycles",
               sectionName(id), haltAddr, haltTimeout);
    end else if (checkErrors != errStart) begin
      failedTests++;
      $display("test %s: FAILED with %0d errors", sectionName(id), checkErrors - errStart);
    end else begin
      $display("test %s: ok", sectionName(id));
    end
  endtask

  initial begin
    rst         = 1'b0;
    checking    = 1'b0;
    timedOut    = 1'b0;
    checkErrors = 0;
    failedTests = 0;
    testsRun    = 0;
    progPtr     = 0;
    haltAddr    = '0;
    lcgState    = 32'he322;
    for (int i = 0; i < 256; i++) instMem[8'(i)] = '0;
    fillData();
    for (int s = 0; s < numSections; s++) begin
      if (!timedOut) runSection(s);
    end
    $display("tests run %0d, tests failed %0d, check errors %0d",
             testsRun, failedTests, checkErrors);
    if (failedTests == 0 && checkErrors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: singleCycleMips.f
+incdir+tests
rtl/mipsPkg.sv
rtl/mipsControl.sv
rtl/mipsAlu.sv
rtl/mipsRegFile.sv
rtl/mipsPc.sv
rtl/singleCycleMips.sv
tests/singleCycleMips_sva.sv
tests/tbSingleCycleMips.sv

// File: Makefile
# Verilator build and run for the single-cycle MIPS core
# override any variable on the command line, e.g. make run LOG=my.log

TOP             ?= tbSingleCycleMips
FILELIST        ?= singleCycleMips.f
LOG             ?= sim.log
BUILD_DIR       ?= obj_dir
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --assert
BIN             := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) \
		-f $(FILELIST) -o V$(TOP)

run: compile
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failures found" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
